// ==== hdl/router_regs_pkg.sv ====
// Router register block definitions

package router_regs_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    localparam int num_ports  = 8;
    localparam int port_idx_w = $clog2(num_ports);
    localparam int addr_w     = 7;
    localparam int drop_cnt_w = 32;

    typedef logic [31:0]          reg_word_t;
    typedef logic [addr_w-1:0]    reg_addr_t;
    typedef logic [num_ports-1:0] port_mask_t;

    localparam reg_word_t version_id = 32'h0100_000A;

    //////////////////////////////
    // Register map
    //////////////////////////////

    // Enable block words sit at the same absolute and local offsets
    localparam int addr_version         = 0;
    localparam int addr_ing_enable_con  = 1;
    localparam int addr_egr_enable_con  = 2;
    localparam int addr_ing_enable_stat = 3;
    localparam int addr_egr_enable_stat = 4;
    localparam int enable_words         = 8;

    // Statistics banks
    localparam int ing_bank_base   = 8;
    localparam int egr_bank_base   = 48;
    localparam int bank_words      = 40;
    localparam int addr_sample_con = 0;
    localparam int words_per_port  = 4;
    localparam int word_idx_w      = $clog2(words_per_port);

    // Word index inside one port's group
    localparam int word_pkt  = 0;
    localparam int word_byte = 1;
    localparam int word_err  = 2;
    localparam int word_drop = 3;

    //////////////////////////////
    // Counter sets
    //////////////////////////////

    typedef struct packed {
        logic [31:0] pkt_cnt;
        logic [31:0] byte_cnt;
        logic [31:0] err_cnt;
    } ing_cnt_set_t;

    typedef struct packed {
        logic [23:0] pkt_cnt;
        logic [31:0] byte_cnt;
        logic [15:0] err_cnt;
    } egr_cnt_set_t;

endpackage

// ==== hdl/reg_bus_if.sv ====
// Register peer local bus

interface reg_bus_if;
    import router_regs_pkg::*;

    // Local word offset inside the peer's range
    reg_addr_t addr;
    reg_word_t wdata;
    logic      write;
    reg_word_t rdata;

    modport host (
        output addr,
        output wdata,
        output write,
        input  rdata
    );

    modport peer (
        input  addr,
        input  wdata,
        input  write,
        output rdata
    );

endinterface

// ==== hdl/wb_reg_slave.sv ====
// Wishbone classic slave
// Address decode to three register peers

module wb_reg_slave (
    input  logic                       clk_ifc,
    input  logic                       rst_n,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  router_regs_pkg::reg_addr_t wb_adr,
    input  router_regs_pkg::reg_word_t wb_dat_w,
    output router_regs_pkg::reg_word_t wb_dat_r,
    output logic                       wb_ack,
    reg_bus_if.host                    enable_bus,
    reg_bus_if.host                    ing_bus,
    reg_bus_if.host                    egr_bus
);
    import router_regs_pkg::*;

    logic      accept;
    logic      in_enable;
    logic      in_ing;
    logic      in_egr;
    reg_word_t rd_sel;

    // The ack cycle blocks a second accept of the same strobe
    assign accept = wb_cyc && wb_stb && !wb_ack;

    assign in_enable = wb_adr < reg_addr_t'(enable_words);
    assign in_ing    = wb_adr >= reg_addr_t'(ing_bank_base) &&
                       wb_adr < reg_addr_t'(ing_bank_base + bank_words);
    assign in_egr    = wb_adr >= reg_addr_t'(egr_bank_base) &&
                       wb_adr < reg_addr_t'(egr_bank_base + bank_words);

    //////////////////////////////
    // Peer requests
    //////////////////////////////

    assign enable_bus.addr  = wb_adr;
    assign enable_bus.wdata = wb_dat_w;
    assign enable_bus.write = accept && wb_we && in_enable;

    assign ing_bus.addr  = wb_adr - reg_addr_t'(ing_bank_base);
    assign ing_bus.wdata = wb_dat_w;
    assign ing_bus.write = accept && wb_we && in_ing;

    assign egr_bus.addr  = wb_adr - reg_addr_t'(egr_bank_base);
    assign egr_bus.wdata = wb_dat_w;
    assign egr_bus.write = accept && wb_we && in_egr;

    //////////////////////////////
    // Read data and ack
    //////////////////////////////

    always_comb begin
        rd_sel = '0;
        if (in_enable) begin
            rd_sel = enable_bus.rdata;
        end else if (in_ing) begin
            rd_sel = ing_bus.rdata;
        end else if (in_egr) begin
            rd_sel = egr_bus.rdata;
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= accept;
        end
    end

    // Held until the next accepted strobe
    always_ff @(posedge clk_ifc) begin
        if (accept) begin
            wb_dat_r <= rd_sel;
        end
    end

endmodule

// ==== hdl/port_enable_regs.sv ====
// Port enable control and status

module port_enable_regs (
    input  logic                        clk_ifc,
    input  logic                        rst_n,
    reg_bus_if.peer                     bus,
    input  router_regs_pkg::port_mask_t ing_ports_connected,
    input  router_regs_pkg::port_mask_t egr_ports_connected,
    output router_regs_pkg::port_mask_t ing_ports_enable,
    output router_regs_pkg::port_mask_t egr_ports_enable
);
    import router_regs_pkg::*;

    port_mask_t ing_enable_con;
    port_mask_t egr_enable_con;
    port_mask_t ing_enable_stat;
    port_mask_t egr_enable_stat;
    reg_word_t  rd_word;

    // All ports come up enabled
    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            ing_enable_con <= '1;
            egr_enable_con <= '1;
        end else if (bus.write) begin
            if (bus.addr == reg_addr_t'(addr_ing_enable_con)) begin
                ing_enable_con <= bus.wdata[num_ports-1:0];
            end
            if (bus.addr == reg_addr_t'(addr_egr_enable_con)) begin
                egr_enable_con <= bus.wdata[num_ports-1:0];
            end
        end
    end

    // Status follows the connected inputs one cycle late
    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            ing_enable_stat <= '0;
            egr_enable_stat <= '0;
        end else begin
            ing_enable_stat <= ing_ports_connected;
            egr_enable_stat <= egr_ports_connected;
        end
    end

    assign ing_ports_enable = ing_enable_con;
    assign egr_ports_enable = egr_enable_con;

    always_comb begin
        case (bus.addr)
            reg_addr_t'(addr_version):         rd_word = version_id;
            reg_addr_t'(addr_ing_enable_con):  rd_word = reg_word_t'(ing_enable_con);
            reg_addr_t'(addr_egr_enable_con):  rd_word = reg_word_t'(egr_enable_con);
            reg_addr_t'(addr_ing_enable_stat): rd_word = reg_word_t'(ing_enable_stat);
            reg_addr_t'(addr_egr_enable_stat): rd_word = reg_word_t'(egr_enable_stat);
            default:                           rd_word = '0;
        endcase
    end

    assign bus.rdata = rd_word;

endmodule

// ==== hdl/port_stats_bank.sv ====
// Per-direction port statistics bank

module port_stats_bank #(
    parameter type cnt_set_t = router_regs_pkg::ing_cnt_set_t
) (
    input  logic                        clk_ifc,
    input  logic                        rst_n,
    reg_bus_if.peer                     bus,
    input  cnt_set_t                    cnts [router_regs_pkg::num_ports],
    input  router_regs_pkg::port_mask_t buf_full_drop
);
    import router_regs_pkg::*;

    port_mask_t            sample;
    port_mask_t            sample_d;
    port_mask_t            sample_rise;
    port_mask_t            drop_q;
    port_mask_t            drop_q_d;
    port_mask_t            drop_rise;
    logic [drop_cnt_w-1:0] drop_cnt  [num_ports];
    logic [drop_cnt_w-1:0] snap_drop [num_ports];
    cnt_set_t              snap_cnt  [num_ports];
    reg_addr_t             slot;
    logic                  slot_valid;
    logic [port_idx_w-1:0] slot_port;
    logic [word_idx_w-1:0] slot_word;
    reg_word_t             rd_word;

    //////////////////////////////
    // Sample control and edges
    //////////////////////////////

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            sample   <= '0;
            sample_d <= '0;
            drop_q   <= '0;
            drop_q_d <= '0;
        end else begin
            sample_d <= sample;
            drop_q   <= buf_full_drop;
            drop_q_d <= drop_q;
            if (bus.write && bus.addr == reg_addr_t'(addr_sample_con)) begin
                sample <= bus.wdata[num_ports-1:0];
            end
        end
    end

    assign sample_rise = sample & ~sample_d;
    assign drop_rise   = drop_q & ~drop_q_d;

    //////////////////////////////
    // Drop counters and snapshots
    //////////////////////////////

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            for (int p = 0; p < num_ports; p++) begin
                drop_cnt[p]  <= '0;
                snap_drop[p] <= '0;
                snap_cnt[p]  <= '0;
            end
        end else begin
            for (int p = 0; p < num_ports; p++) begin
                if (sample_rise[p]) begin
                    snap_cnt[p]  <= cnts[p];
                    snap_drop[p] <= drop_cnt[p];
                    // A drop on the snapshot cycle opens the next interval
                    drop_cnt[p]  <= drop_cnt_w'(drop_rise[p]);
                end else if (drop_rise[p]) begin
                    drop_cnt[p] <= drop_cnt[p] + 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // Read decode
    //////////////////////////////

    // Port words start one past the sample register
    assign slot       = bus.addr - reg_addr_t'(1);
    assign slot_valid = bus.addr != reg_addr_t'(addr_sample_con) &&
                        bus.addr <= reg_addr_t'(num_ports * words_per_port);
    assign slot_port  = slot[word_idx_w +: port_idx_w];
    assign slot_word  = slot[word_idx_w-1:0];

    always_comb begin
        rd_word = '0;
        if (bus.addr == reg_addr_t'(addr_sample_con)) begin
            rd_word = reg_word_t'(sample);
        end else if (slot_valid) begin
            case (slot_word)
                word_pkt:  rd_word = reg_word_t'(snap_cnt[slot_port].pkt_cnt);
                word_byte: rd_word = reg_word_t'(snap_cnt[slot_port].byte_cnt);
                word_err:  rd_word = reg_word_t'(snap_cnt[slot_port].err_cnt);
                word_drop: rd_word = reg_word_t'(snap_drop[slot_port]);
                default:   rd_word = '0;
            endcase
        end
    end

    assign bus.rdata = rd_word;

endmodule

// ==== hdl/router_regs_top.sv ====
// Router control and statistics registers

module router_regs_top (
    input  logic                          clk_ifc,
    input  logic                          rst_n,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  router_regs_pkg::reg_addr_t    wb_adr,
    input  router_regs_pkg::reg_word_t    wb_dat_w,
    output router_regs_pkg::reg_word_t    wb_dat_r,
    output logic                          wb_ack,
    output router_regs_pkg::port_mask_t   ing_ports_enable,
    output router_regs_pkg::port_mask_t   egr_ports_enable,
    input  router_regs_pkg::port_mask_t   ing_ports_connected,
    input  router_regs_pkg::port_mask_t   egr_ports_connected,
    input  router_regs_pkg::ing_cnt_set_t ing_cnts [router_regs_pkg::num_ports],
    input  router_regs_pkg::egr_cnt_set_t egr_cnts [router_regs_pkg::num_ports],
    input  router_regs_pkg::port_mask_t   ing_buf_full_drop,
    input  router_regs_pkg::port_mask_t   egr_buf_full_drop
);
    import router_regs_pkg::*;

    reg_bus_if enable_bus ();
    reg_bus_if ing_bus ();
    reg_bus_if egr_bus ();

    wb_reg_slave u_slave (
        .clk_ifc    (clk_ifc),
        .rst_n      (rst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .enable_bus (enable_bus.host),
        .ing_bus    (ing_bus.host),
        .egr_bus    (egr_bus.host)
    );

    port_enable_regs u_enable (
        .clk_ifc             (clk_ifc),
        .rst_n               (rst_n),
        .bus                 (enable_bus.peer),
        .ing_ports_connected (ing_ports_connected),
        .egr_ports_connected (egr_ports_connected),
        .ing_ports_enable    (ing_ports_enable),
        .egr_ports_enable    (egr_ports_enable)
    );

    port_stats_bank #(
        .cnt_set_t (ing_cnt_set_t)
    ) ing_stats (
        .clk_ifc       (clk_ifc),
        .rst_n         (rst_n),
        .bus           (ing_bus.peer),
        .cnts          (ing_cnts),
        .buf_full_drop (ing_buf_full_drop)
    );

    // Narrow egress counts are zero-extended inside the bank
    port_stats_bank #(
        .cnt_set_t (egr_cnt_set_t)
    ) egr_stats (
        .clk_ifc       (clk_ifc),
        .rst_n         (rst_n),
        .bus           (egr_bus.peer),
        .cnts          (egr_cnts),
        .buf_full_drop (egr_buf_full_drop)
    );

endmodule

// ==== verif/router_regs_tb.sv ====
// Router register block testbench

module router_regs_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import router_regs_pkg::*;

    localparam int rounds = 6;
    // About ten runs per round and eight for the reset sweep
    localparam int runs = rounds * 10 + 8;

    logic         clk_ifc;
    logic         rst_n;
    logic         wb_cyc;
    logic         wb_stb;
    logic         wb_we;
    reg_addr_t    wb_adr;
    reg_word_t    wb_dat_w;
    reg_word_t    wb_dat_r;
    logic         wb_ack;
    port_mask_t   ing_ports_enable;
    port_mask_t   egr_ports_enable;
    port_mask_t   ing_ports_connected;
    port_mask_t   egr_ports_connected;
    ing_cnt_set_t ing_cnts [num_ports];
    egr_cnt_set_t egr_cnts [num_ports];
    port_mask_t   ing_buf_full_drop;
    port_mask_t   egr_buf_full_drop;

    int seed = 32'h797e_93b7;
    int word_errs = 0;
    int mask_errs = 0;
    int ack_errs = 0;
    int bus_errs = 0;

    // Reference model state
    port_mask_t   m_ing_con = '1;
    port_mask_t   m_egr_con = '1;
    port_mask_t   m_ing_conn = '0;
    port_mask_t   m_egr_conn = '0;
    port_mask_t   m_ing_sample = '0;
    port_mask_t   m_egr_sample = '0;
    ing_cnt_set_t m_ing_snap [num_ports];
    egr_cnt_set_t m_egr_snap [num_ports];
    reg_word_t    m_ing_drop_snap [num_ports];
    reg_word_t    m_egr_drop_snap [num_ports];
    int           m_ing_drops [num_ports];
    int           m_egr_drops [num_ports];

    router_regs_top dut (
        .clk_ifc             (clk_ifc),
        .rst_n               (rst_n),
        .wb_cyc              (wb_cyc),
        .wb_stb              (wb_stb),
        .wb_we               (wb_we),
        .wb_adr              (wb_adr),
        .wb_dat_w            (wb_dat_w),
        .wb_dat_r            (wb_dat_r),
        .wb_ack              (wb_ack),
        .ing_ports_enable    (ing_ports_enable),
        .egr_ports_enable    (egr_ports_enable),
        .ing_ports_connected (ing_ports_connected),
        .egr_ports_connected (egr_ports_connected),
        .ing_cnts            (ing_cnts),
        .egr_cnts            (egr_cnts),
        .ing_buf_full_drop   (ing_buf_full_drop),
        .egr_buf_full_drop   (egr_buf_full_drop)
    );

    initial begin
        clk_ifc = 1'b0;
        forever #2 clk_ifc = ~clk_ifc;
    end

    initial begin
        #(200 + runs * 40 * 4);
        $display("Watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_word(input string name, input reg_word_t exp, input reg_word_t act);
        if (act !== exp) begin
            word_errs++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_mask(input string name, input port_mask_t exp, input port_mask_t act);
        if (act !== exp) begin
            mask_errs++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_ack_len(input string name, input int exp, input int act);
        if (act != exp) begin
            ack_errs++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    //////////////////////////////
    // Wishbone driver
    //////////////////////////////

    task automatic bus_transfer(input logic we, input reg_addr_t adr, input reg_word_t wdat,
                                output reg_word_t rdat);
        int waited;
        waited = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        do begin
            @(negedge clk_ifc);
            waited++;
        end while (!wb_ack && waited < 4);
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!wb_ack) begin
            bus_errs++;
            $display("No ack within 4 cycles for the access to address %0d", adr);
        end
        @(negedge clk_ifc);
        if (waited < 4) begin
            check_ack_len($sformatf("ack length @%0d", adr), 1, wb_ack ? 2 : 1);
        end
    endtask

    task automatic wb_write(input reg_addr_t adr, input reg_word_t data);
        reg_word_t unused;
        bus_transfer(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input reg_addr_t adr, output reg_word_t data);
        bus_transfer(1'b0, adr, '0, data);
    endtask

    //////////////////////////////
    // Model
    //////////////////////////////

    function automatic reg_word_t model_word(input reg_addr_t adr);
        int        off;
        int        p;
        int        k;
        logic      egr;
        reg_word_t w;
        w = '0;
        if (adr == addr_version) begin
            w = 32'h0100_000A;
        end else if (adr == addr_ing_enable_con) begin
            w = {24'h0, m_ing_con};
        end else if (adr == addr_egr_enable_con) begin
            w = {24'h0, m_egr_con};
        end else if (adr == addr_ing_enable_stat) begin
            w = {24'h0, m_ing_conn};
        end else if (adr == addr_egr_enable_stat) begin
            w = {24'h0, m_egr_conn};
        end else if (adr >= ing_bank_base && adr < egr_bank_base + bank_words) begin
            egr = adr >= egr_bank_base;
            off = egr ? adr - egr_bank_base : adr - ing_bank_base;
            p   = (off - 1) / words_per_port;
            k   = (off - 1) % words_per_port;
            if (off == 0) begin
                w = {24'h0, egr ? m_egr_sample : m_ing_sample};
            end else if (p >= num_ports) begin
                // Tail of the bank past the last port
                w = '0;
            end else if (!egr) begin
                case (k)
                    0:       w = m_ing_snap[p].pkt_cnt;
                    1:       w = m_ing_snap[p].byte_cnt;
                    2:       w = m_ing_snap[p].err_cnt;
                    default: w = m_ing_drop_snap[p];
                endcase
            end else begin
                case (k)
                    0:       w = {8'h00, m_egr_snap[p].pkt_cnt};
                    1:       w = m_egr_snap[p].byte_cnt;
                    2:       w = {16'h0000, m_egr_snap[p].err_cnt};
                    default: w = m_egr_drop_snap[p];
                endcase
            end
        end
        return w;
    endfunction

    // Bus write plus the model update it implies
    task automatic write_reg(input reg_addr_t adr, input reg_word_t data);
        port_mask_t rise;
        wb_write(adr, data);
        if (adr == addr_ing_enable_con) begin
            m_ing_con = data[7:0];
        end else if (adr == addr_egr_enable_con) begin
            m_egr_con = data[7:0];
        end else if (adr == ing_bank_base) begin
            rise = data[7:0] & ~m_ing_sample;
            m_ing_sample = data[7:0];
            for (int p = 0; p < num_ports; p++) begin
                if (rise[p]) begin
                    m_ing_snap[p]      = ing_cnts[p];
                    m_ing_drop_snap[p] = m_ing_drops[p];
                    m_ing_drops[p]     = 0;
                end
            end
        end else if (adr == egr_bank_base) begin
            rise = data[7:0] & ~m_egr_sample;
            m_egr_sample = data[7:0];
            for (int p = 0; p < num_ports; p++) begin
                if (rise[p]) begin
                    m_egr_snap[p]      = egr_cnts[p];
                    m_egr_drop_snap[p] = m_egr_drops[p];
                    m_egr_drops[p]     = 0;
                end
            end
        end
    endtask

    task automatic check_reg(input string test, input reg_addr_t adr);
        reg_word_t data;
        wb_read(adr, data);
        check_word($sformatf("%s @%0d", test, adr), model_word(adr), data);
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic enable_test();
        write_reg(addr_ing_enable_con, $random(seed));
        write_reg(addr_egr_enable_con, $random(seed));
        check_mask("ing enable output", m_ing_con, ing_ports_enable);
        check_mask("egr enable output", m_egr_con, egr_ports_enable);
        check_reg("enable control", addr_ing_enable_con);
        check_reg("enable control", addr_egr_enable_con);
        m_ing_conn = $random(seed);
        m_egr_conn = $random(seed);
        ing_ports_connected = m_ing_conn;
        egr_ports_connected = m_egr_conn;
        repeat (2) @(negedge clk_ifc);
        check_reg("enable status", addr_ing_enable_stat);
        check_reg("enable status", addr_egr_enable_stat);
    endtask

    task automatic unmapped_test();
        reg_addr_t adr;
        int        k;
        if ($random(seed) & 1) begin
            adr = reg_addr_t'(88 + {$random(seed)} % 40);
        end else begin
            adr = reg_addr_t'(5 + {$random(seed)} % 3);
        end
        check_reg("unmapped read", adr);
        write_reg(adr, $random(seed));
        check_reg("unmapped after write", adr);
        // Version or one of the status words
        k = {$random(seed)} % 3;
        adr = reg_addr_t'(k == 0 ? 0 : k + 2);
        write_reg(adr, $random(seed));
        check_reg("read-only after write", adr);
        check_reg("control after stray write", addr_ing_enable_con);
        check_reg("control after stray write", addr_egr_enable_con);
    endtask

    task automatic sample_both(input reg_word_t ing_mask, input reg_word_t egr_mask);
        write_reg(ing_bank_base, '0);
        write_reg(egr_bank_base, '0);
        write_reg(ing_bank_base, ing_mask);
        write_reg(egr_bank_base, egr_mask);
        repeat (2) @(negedge clk_ifc);
    endtask

    task automatic snapshot_test();
        logic [95:0] rnd;
        for (int p = 0; p < num_ports; p++) begin
            rnd = {$random(seed), $random(seed), $random(seed)};
            ing_cnts[p] = rnd;
            rnd = {$random(seed), $random(seed), $random(seed)};
            egr_cnts[p] = rnd[71:0];
        end
        sample_both($random(seed), $random(seed));
        for (int a = ing_bank_base; a < egr_bank_base + bank_words; a++) begin
            check_reg("snapshot", reg_addr_t'(a));
        end
    endtask

    task automatic drop_test();
        int ing_n [num_ports];
        int egr_n [num_ports];
        int most;
        most = 0;
        for (int p = 0; p < num_ports; p++) begin
            ing_n[p] = {$random(seed)} % 6;
            egr_n[p] = {$random(seed)} % 6;
            most = ing_n[p] > most ? ing_n[p] : most;
            most = egr_n[p] > most ? egr_n[p] : most;
        end
        // One-cycle pulses with one-cycle gaps
        for (int i = 0; i < most; i++) begin
            for (int p = 0; p < num_ports; p++) begin
                ing_buf_full_drop[p] = ing_n[p] > i;
                egr_buf_full_drop[p] = egr_n[p] > i;
            end
            @(negedge clk_ifc);
            ing_buf_full_drop = '0;
            egr_buf_full_drop = '0;
            @(negedge clk_ifc);
        end
        for (int p = 0; p < num_ports; p++) begin
            m_ing_drops[p] += ing_n[p];
            m_egr_drops[p] += egr_n[p];
        end
        repeat (3) @(negedge clk_ifc);
        for (int s = 0; s < 2; s++) begin
            sample_both(32'hFF, 32'hFF);
            for (int p = 0; p < num_ports; p++) begin
                check_reg("drop count", reg_addr_t'(ing_bank_base + 4 + 4 * p));
                check_reg("drop count", reg_addr_t'(egr_bank_base + 4 + 4 * p));
            end
        end
    endtask

    initial begin
        rst_n               = 1'b0;
        wb_cyc              = 1'b0;
        wb_stb              = 1'b0;
        wb_we               = 1'b0;
        wb_adr              = '0;
        wb_dat_w            = '0;
        ing_ports_connected = '0;
        egr_ports_connected = '0;
        ing_buf_full_drop   = '0;
        egr_buf_full_drop   = '0;
        for (int p = 0; p < num_ports; p++) begin
            ing_cnts[p]        = '0;
            egr_cnts[p]        = '0;
            m_ing_snap[p]      = '0;
            m_egr_snap[p]      = '0;
            m_ing_drop_snap[p] = '0;
            m_egr_drop_snap[p] = '0;
            m_ing_drops[p]     = 0;
            m_egr_drops[p]     = 0;
        end
        repeat (16) @(negedge clk_ifc);
        rst_n = 1'b1;
        @(negedge clk_ifc);

        check_mask("reset ing enable", 8'hFF, ing_ports_enable);
        check_mask("reset egr enable", 8'hFF, egr_ports_enable);
        for (int a = 0; a < 2 ** addr_w; a++) begin
            check_reg("reset value", reg_addr_t'(a));
        end

        for (int r = 0; r < rounds; r++) begin
            enable_test();
            unmapped_test();
            snapshot_test();
            drop_test();
        end

        $display("Errors: %0d word, %0d mask, %0d ack length, %0d missing ack",
                 word_errs, mask_errs, ack_errs, bus_errs);
        if (word_errs + mask_errs + ack_errs + bus_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hdl/router_regs_pkg.sv
hdl/reg_bus_if.sv
hdl/wb_reg_slave.sv
hdl/port_enable_regs.sv
hdl/port_stats_bank.sv
hdl/router_regs_top.sv
verif/router_regs_tb.sv
